// File: design/hpsdr_settings.svh
// Frame geometry, header bytes, frame type codes and register offsets
`ifndef HPSDR_SETTINGS_SVH
`define HPSDR_SETTINGS_SVH

// Frame geometry in bytes
`define HPSDR_FRAME_BYTES  1032
`define HPSDR_SUB_BYTES    512
`define HPSDR_HDR_BYTES    8
`define HPSDR_WIDE_SAMPLES 512

// Header and sync bytes
`define HPSDR_MAGIC0       8'hef
`define HPSDR_MAGIC1       8'hfe
`define HPSDR_EP_BYTE      8'h01
`define HPSDR_TYPE_IQ      8'h06
`define HPSDR_TYPE_WIDE    8'h04
`define HPSDR_SYNC         8'h7f

// Register offsets
`define REG_CTRL           4'h0
`define REG_BS_PERIOD      4'h4

`endif

// File: design/hpsdr_pkg.sv
// Shared types for the AXI4-Lite channels, sample words and byte beats
package hpsdr_pkg;

  // Master side of the register bus
  typedef struct packed {
    logic        aw_valid;
    logic [3:0]  aw_addr;
    logic        w_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_ready;
    logic        ar_valid;
    logic [3:0]  ar_addr;
    logic        r_ready;
  } axil_req_t;

  // Slave side of the register bus
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  // Last marks the final word of a receiver round
  typedef struct packed {
    logic [23:0] data;
    logic        last;
  } iq_word_t;

  typedef struct packed {
    logic signed [11:0] data;
  } bs_sample_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

endpackage

// File: design/hpsdr_cfg_regs.sv
// AXI4-Lite register slave holding the run bit and the bandscope period
`timescale 1ns/1ps
`include "hpsdr_settings.svh"

module hpsdr_cfg_regs import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  output logic       run,
  output logic [6:0] bs_period
);

  logic        wr_ack;
  logic        b_valid;
  logic        ar_ack;
  logic        r_valid;
  logic [31:0] r_data;
  logic        wr_go;
  logic        rd_go;
  logic [31:0] rd_mux;

  // Accept a write only with address and data both present
  assign wr_go = axil_req.aw_valid && axil_req.w_valid && !wr_ack && !b_valid;
  assign rd_go = axil_req.ar_valid && !ar_ack && !r_valid;

  always_comb begin
    case (axil_req.ar_addr)
      `REG_CTRL:      rd_mux = {31'd0, run};
      `REG_BS_PERIOD: rd_mux = {25'd0, bs_period};
      default:        rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ack    <= 1'b0;
      b_valid   <= 1'b0;
      ar_ack    <= 1'b0;
      r_valid   <= 1'b0;
      run       <= 1'b0;
      bs_period <= 7'd0;
    end else begin
      wr_ack <= wr_go;
      ar_ack <= rd_go;

      if (wr_ack) begin
        b_valid <= 1'b1;
      end else if (b_valid && axil_req.b_ready) begin
        b_valid <= 1'b0;
      end

      if (ar_ack) begin
        r_valid <= 1'b1;
      end else if (r_valid && axil_req.r_ready) begin
        r_valid <= 1'b0;
      end

      // Both fields live in byte lane 0
      if (wr_ack && axil_req.w_strb[0]) begin
        case (axil_req.aw_addr)
          `REG_CTRL:      run <= axil_req.w_data[0];
          `REG_BS_PERIOD: bs_period <= axil_req.w_data[6:0];
          default:        ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_ack) begin
      r_data <= rd_mux;
    end
  end

  always_comb begin
    axil_rsp.aw_ready = wr_ack;
    axil_rsp.w_ready  = wr_ack;
    axil_rsp.b_valid  = b_valid;
    axil_rsp.b_resp   = 2'b00;
    axil_rsp.ar_ready = ar_ack;
    axil_rsp.r_valid  = r_valid;
    axil_rsp.r_data   = r_data;
    axil_rsp.r_resp   = 2'b00;
  end

endmodule

// File: design/sample_skid_buf.sv
// Two-entry valid/ready register slice with a type parameter for the payload
`timescale 1ns/1ps

module sample_skid_buf #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_free;

  // Upstream ready comes from a flop, never from out_ready
  assign in_ready = !skid_valid;
  assign out_free = out_ready || !out_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : in_data;
    end else if (in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

// File: design/iq_frame_gen.sv
// Type-06 IQ frame builder with sync, C&C, sample rounds, mic bytes and padding
`timescale 1ns/1ps
`include "hpsdr_settings.svh"

module iq_frame_gen import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  iq_word_t   iq_data,
  input  logic       iq_valid,
  output logic       iq_ready,
  output byte_beat_t beat,
  output logic       beat_valid,
  input  logic       beat_ready
);

  typedef enum logic [2:0] {S_HDR, S_SYNC, S_DATA, S_MIC, S_PAD} state_t;

  state_t      state;
  logic [2:0]  idx;
  logic [9:0]  sub_left;
  logic        sub_no;
  logic [9:0]  round_cnt;
  logic [1:0]  c0_addr;
  logic [31:0] seq;
  logic        fire;
  logic        sub_end;
  logic        room;

  assign fire    = beat_valid && beat_ready;
  // sub_left counts the byte on offer
  assign sub_end = (state != S_HDR) && (sub_left == 10'd1);
  // Enough space left for a round as long as the one now ending
  assign room    = (sub_left - 10'd1) >= (round_cnt + 10'd1);
  // Word popped with its low byte
  assign iq_ready = (state == S_DATA) && (idx == 3'd2) && beat_ready;

  always_comb begin
    beat.data  = 8'h00;
    beat.last  = 1'b0;
    beat_valid = 1'b1;
    case (state)
      S_HDR: begin
        case (idx)
          3'd0:    beat.data = `HPSDR_MAGIC0;
          3'd1:    beat.data = `HPSDR_MAGIC1;
          3'd2:    beat.data = `HPSDR_EP_BYTE;
          3'd3:    beat.data = `HPSDR_TYPE_IQ;
          3'd4:    beat.data = seq[31:24];
          3'd5:    beat.data = seq[23:16];
          3'd6:    beat.data = seq[15:8];
          default: beat.data = seq[7:0];
        endcase
        // Frame opens only when samples are on hand
        if (idx == 3'd0) begin
          beat_valid = run && iq_valid;
        end
      end
      S_SYNC: begin
        if (idx < 3'd3) begin
          beat.data = `HPSDR_SYNC;
        end else if (idx == 3'd3) begin
          beat.data = {3'b000, c0_addr, 3'b000};
        end
      end
      S_DATA: begin
        beat_valid = iq_valid;
        case (idx)
          3'd0:    beat.data = iq_data.data[23:16];
          3'd1:    beat.data = iq_data.data[15:8];
          default: beat.data = iq_data.data[7:0];
        endcase
      end
      default: beat.data = 8'h00;
    endcase
    beat.last = sub_no && sub_end;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_HDR;
      idx       <= 3'd0;
      sub_left  <= 10'd0;
      sub_no    <= 1'b0;
      round_cnt <= 10'd0;
      c0_addr   <= 2'd0;
      seq       <= 32'd0;
    end else begin
      if (!run && state == S_HDR && idx == 3'd0) begin
        seq <= 32'd0;
      end
      if (fire) begin
        idx <= idx + 3'd1;
        if (state != S_HDR) begin
          sub_left <= sub_left - 10'd1;
        end
        if (state == S_DATA || state == S_MIC) begin
          round_cnt <= round_cnt + 10'd1;
        end
        if (sub_end) begin
          idx <= 3'd0;
          if (sub_no) begin
            state <= S_HDR;
          end else begin
            state    <= S_SYNC;
            sub_no   <= 1'b1;
            sub_left <= 10'(`HPSDR_SUB_BYTES);
          end
        end else begin
          case (state)
            S_HDR: begin
              if (idx == 3'(`HPSDR_HDR_BYTES - 1)) begin
                state    <= S_SYNC;
                idx      <= 3'd0;
                sub_no   <= 1'b0;
                sub_left <= 10'(`HPSDR_SUB_BYTES);
                seq      <= seq + 32'd1;
              end
            end
            S_SYNC: begin
              // C0 address moves on once per subframe
              if (idx == 3'd7) begin
                state     <= S_DATA;
                idx       <= 3'd0;
                c0_addr   <= c0_addr + 2'd1;
                round_cnt <= 10'd0;
              end
            end
            S_DATA: begin
              if (idx == 3'd2) begin
                idx <= 3'd0;
                if (iq_data.last) begin
                  state <= S_MIC;
                end
              end
            end
            S_MIC: begin
              if (idx == 3'd1) begin
                idx       <= 3'd0;
                round_cnt <= 10'd0;
                state     <= room ? S_DATA : S_PAD;
              end
            end
            default: state <= S_PAD;
          endcase
        end
      end
    end
  end

endmodule

// File: design/wide_frame_gen.sv
// Type-04 wideband frame builder from 12-bit bandscope samples
`timescale 1ns/1ps
`include "hpsdr_settings.svh"

module wide_frame_gen import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  bs_sample_t bs_data,
  input  logic       bs_valid,
  output logic       bs_ready,
  output byte_beat_t beat,
  output logic       beat_valid,
  input  logic       beat_ready
);

  typedef enum logic {S_HDR, S_SAMP} state_t;

  state_t      state;
  logic [2:0]  idx;
  logic        half;
  logic [8:0]  samp_cnt;
  logic [31:0] seq;
  logic        fire;
  logic        samp_last;

  assign fire      = beat_valid && beat_ready;
  assign samp_last = (samp_cnt == 9'(`HPSDR_WIDE_SAMPLES - 1));
  // Sample leaves with its high byte
  assign bs_ready  = (state == S_SAMP) && half && beat_ready;

  always_comb begin
    beat.data  = 8'h00;
    beat.last  = 1'b0;
    beat_valid = bs_valid;
    if (state == S_HDR) begin
      case (idx)
        3'd0:    beat.data = `HPSDR_MAGIC0;
        3'd1:    beat.data = `HPSDR_MAGIC1;
        3'd2:    beat.data = `HPSDR_EP_BYTE;
        3'd3:    beat.data = `HPSDR_TYPE_WIDE;
        3'd4:    beat.data = seq[31:24];
        3'd5:    beat.data = seq[23:16];
        3'd6:    beat.data = seq[15:8];
        default: beat.data = seq[7:0];
      endcase
      beat_valid = (idx == 3'd0) ? (run && bs_valid) : 1'b1;
    end else if (half) begin
      beat.data = {{4{bs_data.data[11]}}, bs_data.data[11:8]};
      beat.last = samp_last;
    end else begin
      beat.data = bs_data.data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_HDR;
      idx      <= 3'd0;
      half     <= 1'b0;
      samp_cnt <= 9'd0;
      seq      <= 32'd0;
    end else begin
      if (!run && state == S_HDR && idx == 3'd0) begin
        seq <= 32'd0;
      end
      if (fire) begin
        if (state == S_HDR) begin
          idx <= idx + 3'd1;
          if (idx == 3'(`HPSDR_HDR_BYTES - 1)) begin
            state    <= S_SAMP;
            idx      <= 3'd0;
            half     <= 1'b0;
            samp_cnt <= 9'd0;
            seq      <= seq + 32'd1;
          end
        end else begin
          half <= !half;
          if (half) begin
            samp_cnt <= samp_cnt + 9'd1;
            if (samp_last) begin
              state <= S_HDR;
            end
          end
        end
      end
    end
  end

endmodule

// File: design/frame_arbiter.sv
// Frame-boundary arbiter between IQ and wideband sources with bandscope countdown
`timescale 1ns/1ps

module frame_arbiter import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [6:0] bs_period,
  input  byte_beat_t iq_beat,
  input  logic       iq_valid,
  output logic       iq_ready,
  input  byte_beat_t wide_beat,
  input  logic       wide_valid,
  output logic       wide_ready,
  output byte_beat_t udp_beat,
  output logic       udp_valid,
  input  logic       udp_ready
);

  logic       busy;
  logic       grant_wide;
  logic [6:0] countdown;
  logic       pick_wide;
  logic       sel_wide;

  // Wideband frame is due and ready to go
  assign pick_wide = (bs_period != 7'd0) && (countdown == 7'd0) && wide_valid;
  // Source is locked from the first offered byte to the last
  assign sel_wide  = busy ? grant_wide : pick_wide;

  assign udp_beat   = sel_wide ? wide_beat : iq_beat;
  assign udp_valid  = sel_wide ? wide_valid : iq_valid;
  assign iq_ready   = !sel_wide && udp_ready;
  assign wide_ready = sel_wide && udp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      grant_wide <= 1'b0;
      countdown  <= 7'd0;
    end else if (udp_valid && udp_ready && udp_beat.last) begin
      busy <= 1'b0;
    end else if (!busy && udp_valid) begin
      busy       <= 1'b1;
      grant_wide <= sel_wide;
      if (sel_wide) begin
        countdown <= bs_period;
      end else if (countdown != 7'd0) begin
        countdown <= countdown - 7'd1;
      end
    end
  end

endmodule

// File: design/hpsdr_upstream_top.sv
// Upstream packer top with register slave, skid buffers, frame builders and arbiter
`timescale 1ns/1ps

module hpsdr_upstream_top import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  input  iq_word_t   iq_in,
  input  logic       iq_valid,
  output logic       iq_ready,
  input  bs_sample_t bs_in,
  input  logic       bs_valid,
  output logic       bs_ready,
  output byte_beat_t udp_beat,
  output logic       udp_valid,
  input  logic       udp_ready
);

  logic       run;
  logic [6:0] bs_period;

  iq_word_t   iq_buf_data;
  logic       iq_buf_valid;
  logic       iq_buf_ready;
  bs_sample_t bs_buf_data;
  logic       bs_buf_valid;
  logic       bs_buf_ready;

  byte_beat_t iq_gen_beat;
  logic       iq_gen_valid;
  logic       iq_gen_ready;
  byte_beat_t wide_gen_beat;
  logic       wide_gen_valid;
  logic       wide_gen_ready;

  hpsdr_cfg_regs u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .run       (run),
    .bs_period (bs_period)
  );

  sample_skid_buf #(.payload_t(iq_word_t)) u_iq_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (iq_in),
    .in_valid  (iq_valid),
    .in_ready  (iq_ready),
    .out_data  (iq_buf_data),
    .out_valid (iq_buf_valid),
    .out_ready (iq_buf_ready)
  );

  sample_skid_buf #(.payload_t(bs_sample_t)) u_bs_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (bs_in),
    .in_valid  (bs_valid),
    .in_ready  (bs_ready),
    .out_data  (bs_buf_data),
    .out_valid (bs_buf_valid),
    .out_ready (bs_buf_ready)
  );

  iq_frame_gen u_iq_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .iq_data    (iq_buf_data),
    .iq_valid   (iq_buf_valid),
    .iq_ready   (iq_buf_ready),
    .beat       (iq_gen_beat),
    .beat_valid (iq_gen_valid),
    .beat_ready (iq_gen_ready)
  );

  wide_frame_gen u_wide_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .bs_data    (bs_buf_data),
    .bs_valid   (bs_buf_valid),
    .bs_ready   (bs_buf_ready),
    .beat       (wide_gen_beat),
    .beat_valid (wide_gen_valid),
    .beat_ready (wide_gen_ready)
  );

  frame_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .bs_period  (bs_period),
    .iq_beat    (iq_gen_beat),
    .iq_valid   (iq_gen_valid),
    .iq_ready   (iq_gen_ready),
    .wide_beat  (wide_gen_beat),
    .wide_valid (wide_gen_valid),
    .wide_ready (wide_gen_ready),
    .udp_beat   (udp_beat),
    .udp_valid  (udp_valid),
    .udp_ready  (udp_ready)
  );

endmodule

// File: sim/hpsdr_props.sv
// Bound assertions on stream handshakes and the UDP frame length
`timescale 1ns/1ps
`include "hpsdr_settings.svh"

module hpsdr_props import hpsdr_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input byte_beat_t udp_beat,
  input logic       udp_valid,
  input logic       udp_ready,
  input logic       iq_valid,
  input logic       iq_ready,
  input logic       bs_valid,
  input logic       bs_ready
);

  logic [10:0] xfer_cnt;
  logic        udp_fire;

  assign udp_fire = udp_valid && udp_ready;

  // Transfers since the last frame end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xfer_cnt <= 11'd0;
    end else if (udp_fire) begin
      xfer_cnt <= udp_beat.last ? 11'd0 : xfer_cnt + 11'd1;
    end
  end

  a_udp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    udp_valid && !udp_ready |=> udp_valid && $stable(udp_beat))
    else $error("udp beat changed while stalled");

  a_iq_hold: assert property (@(posedge clk) disable iff (!rst_n)
    iq_valid && !iq_ready |=> iq_valid)
    else $error("iq valid dropped before transfer");

  a_bs_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bs_valid && !bs_ready |=> bs_valid)
    else $error("bandscope valid dropped before transfer");

  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
    udp_fire |-> (udp_beat.last == (xfer_cnt == 11'(`HPSDR_FRAME_BYTES - 1))))
    else $error("frame end not on byte 1032");

endmodule

// File: sim/hpsdr_tb.sv
// Testbench for the upstream packer with drivers, reference model, checker and watchdog
`timescale 1ns/1ps
`include "hpsdr_settings.svh"

module hpsdr_tb import hpsdr_pkg::*; ();

  localparam int ROUND_WORDS = 5;
  localparam int ROUND_BYTES = 3 * ROUND_WORDS + 2;
  // Up to 16 frames at 4 cycles per byte, plus room for register traffic
  localparam int WATCHDOG_CYCLES = 16 * `HPSDR_FRAME_BYTES * 4 + 8000;

  logic       clk;
  logic       rst_n;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;
  iq_word_t   iq_in;
  logic       iq_valid;
  logic       iq_ready;
  bs_sample_t bs_in;
  logic       bs_valid;
  logic       bs_ready;
  byte_beat_t udp_beat;
  logic       udp_valid;
  logic       udp_ready;

  logic [23:0] iq_q[$];
  logic [11:0] bs_q[$];
  logic        stall_en;
  logic        drv_en;
  int          rounds_per_sub;
  logic [6:0]  period_m;
  logic [6:0]  cd_m;
  logic [31:0] iq_seq_m;
  logic [31:0] wide_seq_m;
  logic [1:0]  c0_m;
  logic        cur_wide;
  logic [31:0] cur_seq;
  int          pos;
  logic        in_frame;
  int          frames_done;

  hpsdr_upstream_top u_hpsdr_upstream_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .iq_in     (iq_in),
    .iq_valid  (iq_valid),
    .iq_ready  (iq_ready),
    .bs_in     (bs_in),
    .bs_valid  (bs_valid),
    .bs_ready  (bs_ready),
    .udp_beat  (udp_beat),
    .udp_valid (udp_valid),
    .udp_ready (udp_ready)
  );

  // Hold checks watch the skid buffer outputs toward the generators
  bind hpsdr_upstream_top hpsdr_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .udp_beat  (udp_beat),
    .udp_valid (udp_valid),
    .udp_ready (udp_ready),
    .iq_valid  (iq_buf_valid),
    .iq_ready  (iq_buf_ready),
    .bs_valid  (bs_buf_valid),
    .bs_ready  (bs_buf_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = !clk;
  end

  // Whole rounds that fit a subframe; the first one always starts
  function automatic int rounds_in_subframe();
    int left;
    int n;
    left = `HPSDR_SUB_BYTES - 8 - ROUND_BYTES;
    n = 1;
    while (left >= ROUND_BYTES) begin
      left = left - ROUND_BYTES;
      n = n + 1;
    end
    return n;
  endfunction

  // Reference byte at a position of the current frame
  function automatic logic [7:0] expected_byte(input int p);
    int off;
    int sub;
    int rnd;
    int r;
    logic [23:0] w;
    logic [11:0] s;
    logic [7:0]  b;
    b = 8'h00;
    if (p < `HPSDR_HDR_BYTES) begin
      case (p)
        0:       b = `HPSDR_MAGIC0;
        1:       b = `HPSDR_MAGIC1;
        2:       b = `HPSDR_EP_BYTE;
        3:       b = cur_wide ? `HPSDR_TYPE_WIDE : `HPSDR_TYPE_IQ;
        default: b = cur_seq[8 * (7 - p) +: 8];
      endcase
    end else if (cur_wide) begin
      s = bs_q[(p - 8) / 2];
      if ((p - 8) % 2 == 0) begin
        b = s[7:0];
      end else begin
        b = s[11] ? {4'hf, s[11:8]} : {4'h0, s[11:8]};
      end
    end else begin
      sub = (p - 8) / `HPSDR_SUB_BYTES;
      off = (p - 8) % `HPSDR_SUB_BYTES;
      if (off < 3) begin
        b = `HPSDR_SYNC;
      end else if (off == 3) begin
        b = 8'(((c0_m + sub) % 4) * 8);
      end else if (off >= 8) begin
        rnd = (off - 8) / ROUND_BYTES;
        r   = (off - 8) % ROUND_BYTES;
        // Mic bytes and padding stay zero
        if (rnd < rounds_per_sub && r < 3 * ROUND_WORDS) begin
          w = iq_q[(sub * rounds_per_sub + rnd) * ROUND_WORDS + r / 3];
          b = w[8 * (2 - r % 3) +: 8];
        end
      end
    end
    return b;
  endfunction

  // Arbitration at a frame boundary with the bandscope buffer full by then
  task automatic pick_next_frame();
    if (period_m != 7'd0 && cd_m == 7'd0) begin
      cur_wide = 1'b1;
      cd_m     = period_m;
      cur_seq  = wide_seq_m;
    end else begin
      cur_wide = 1'b0;
      if (cd_m != 7'd0) begin
        cd_m = cd_m - 7'd1;
      end
      cur_seq = iq_seq_m;
    end
  endtask

  task automatic retire_frame();
    if (cur_wide) begin
      repeat (`HPSDR_WIDE_SAMPLES) void'(bs_q.pop_front());
      wide_seq_m = wide_seq_m + 32'd1;
    end else begin
      repeat (2 * rounds_per_sub * ROUND_WORDS) void'(iq_q.pop_front());
      iq_seq_m = iq_seq_m + 32'd1;
      c0_m     = c0_m + 2'd2;
    end
    frames_done = frames_done + 1;
  endtask

  // Checker on the UDP port sampled mid-cycle
  initial begin
    logic [7:0] exp_data;
    logic       exp_last;
    forever begin
      @(negedge clk);
      if (rst_n && udp_valid && udp_ready) begin
        if (pos == 0) begin
          pick_next_frame();
          in_frame = 1'b1;
        end
        exp_data = expected_byte(pos);
        exp_last = (pos == `HPSDR_FRAME_BYTES - 1);
        assert (udp_beat.data == exp_data) else begin
          $display("ERR udp_beat.data exp=%h got=%h at byte %0d of frame %0d",
                   exp_data, udp_beat.data, pos, frames_done);
          $display("test failed");
          $fatal(1);
        end
        assert (udp_beat.last == exp_last) else begin
          $display("ERR udp_beat.last exp=%h got=%h at byte %0d of frame %0d",
                   exp_last, udp_beat.last, pos, frames_done);
          $display("test failed");
          $fatal(1);
        end
        pos = pos + 1;
        if (pos == `HPSDR_FRAME_BYTES) begin
          retire_frame();
          pos      = 0;
          in_frame = 1'b0;
        end
      end
    end
  end

  // IQ source with five words per round and gaps
  initial begin
    logic took;
    int   word_idx;
    word_idx = 0;
    forever begin
      @(negedge clk);
      took = iq_valid && iq_ready;
      if (took) begin
        iq_q.push_back(iq_in.data);
      end
      @(posedge clk);
      #2;
      if (took || !iq_valid) begin
        if (drv_en && ($urandom % 8 != 0)) begin
          iq_in.data = 24'($urandom);
          iq_in.last = (word_idx == ROUND_WORDS - 1);
          iq_valid   = 1'b1;
          word_idx   = (word_idx == ROUND_WORDS - 1) ? 0 : word_idx + 1;
        end else begin
          iq_valid = 1'b0;
        end
      end
    end
  end

  // Bandscope source with gaps
  initial begin
    logic took;
    forever begin
      @(negedge clk);
      took = bs_valid && bs_ready;
      if (took) begin
        bs_q.push_back(bs_in.data);
      end
      @(posedge clk);
      #2;
      if (took || !bs_valid) begin
        if (drv_en && ($urandom % 8 != 0)) begin
          bs_in.data = 12'($urandom);
          bs_valid   = 1'b1;
        end else begin
          bs_valid = 1'b0;
        end
      end
    end
  end

  // Sink stalls
  initial begin
    forever begin
      @(posedge clk);
      #2;
      udp_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before all frames came out");
    $display("test failed");
    $fatal(1);
  end

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    @(posedge clk);
    #2;
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    do @(negedge clk); while (!axil_rsp.aw_ready);
    // Address and data channels are taken in the same cycle
    assert (axil_rsp.w_ready) else begin
      $display("ERR axil_rsp.w_ready exp=1 got=%h", axil_rsp.w_ready);
      $display("test failed");
      $fatal(1);
    end
    @(posedge clk);
    #2;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    axil_req.b_ready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.b_valid);
    assert (axil_rsp.b_resp == 2'b00) else begin
      $display("ERR axil_rsp.b_resp exp=0 got=%h", axil_rsp.b_resp);
      $display("test failed");
      $fatal(1);
    end
    @(posedge clk);
    #2;
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    do @(negedge clk); while (!axil_rsp.ar_ready);
    @(posedge clk);
    #2;
    axil_req.ar_valid = 1'b0;
    axil_req.r_ready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.r_valid);
    data = axil_rsp.r_data;
    assert (axil_rsp.r_resp == 2'b00) else begin
      $display("ERR axil_rsp.r_resp addr=%h exp=0 got=%h", addr, axil_rsp.r_resp);
      $display("test failed");
      $fatal(1);
    end
    @(posedge clk);
    #2;
    axil_req.r_ready = 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_val);
    logic [31:0] got;
    axil_read(addr, got);
    assert (got == exp_val) else begin
      $display("ERR axil_rsp.r_data addr=%h exp=%h got=%h", addr, exp_val, got);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic start_run();
    iq_seq_m   = 32'd0;
    wide_seq_m = 32'd0;
    stall_en   = 1'b1;
    axil_write(`REG_CTRL, 32'd1, 4'h1);
  endtask

  // Sink runs free so a granted frame never waits on a dropped run
  task automatic stop_run();
    stall_en = 1'b0;
    repeat (2) @(posedge clk);
    axil_write(`REG_CTRL, 32'd0, 4'h1);
    wait (!in_frame);
    repeat (8) @(posedge clk);
  endtask

  task automatic set_period(input logic [6:0] p);
    axil_write(`REG_BS_PERIOD, {25'd0, p}, 4'h1);
    period_m = p;
  endtask

  initial begin
    int base;
    void'($urandom(32'heacd));
    rst_n          = 1'b0;
    axil_req       = '0;
    iq_in          = '0;
    iq_valid       = 1'b0;
    bs_in          = '0;
    bs_valid       = 1'b0;
    udp_ready      = 1'b1;
    stall_en       = 1'b0;
    drv_en         = 1'b0;
    rounds_per_sub = rounds_in_subframe();
    period_m       = 7'd0;
    cd_m           = 7'd0;
    iq_seq_m       = 32'd0;
    wide_seq_m     = 32'd0;
    c0_m           = 2'd0;
    pos            = 0;
    in_frame       = 1'b0;
    frames_done    = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n  = 1'b1;
    drv_en = 1'b1;

    // Register access, strobes and an unmapped offset
    read_expect(`REG_CTRL, 32'd0);
    read_expect(`REG_BS_PERIOD, 32'd0);
    set_period(7'h55);
    read_expect(`REG_BS_PERIOD, 32'h55);
    axil_write(`REG_CTRL, 32'd1, 4'h0);
    read_expect(`REG_CTRL, 32'd0);
    axil_write(4'h8, 32'hdeadbeef, 4'hf);
    read_expect(4'h8, 32'd0);
    set_period(7'd0);

    // IQ frames only
    start_run();
    read_expect(`REG_CTRL, 32'd1);
    base = frames_done;
    wait (frames_done >= base + 3);
    stop_run();

    // Wideband interleaved every two IQ frames
    set_period(7'd2);
    start_run();
    base = frames_done;
    wait (frames_done >= base + 6);
    stop_run();

    // Restart clears both sequence numbers
    start_run();
    base = frames_done;
    wait (frames_done >= base + 3);
    stop_run();

    $display("test passed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+design
design/hpsdr_pkg.sv
design/hpsdr_cfg_regs.sv
design/sample_skid_buf.sv
design/iq_frame_gen.sv
design/wide_frame_gen.sv
design/frame_arbiter.sv
design/hpsdr_upstream_top.sv
sim/hpsdr_props.sv
sim/hpsdr_tb.sv

// File: Makefile
TOP := hpsdr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)
	verilator --lint-only -f flist.f --top-module hpsdr_upstream_top

clean:
	rm -rf obj_dir
